// File: Makefile
# Verilator build and run of the nn_layer testbench.

VERILATOR ?= verilator
TOP ?= nn_layer_tb
FILELIST ?= nn_layer.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= test passed
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG PASS_MSG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "PASS"; \
	else \
		echo "FAIL: pass message not found in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: nn_layer.f
+incdir+verilog
verilog/fp_pkg.sv
verilog/nn_pkg.sv
verilog/float_mult.sv
verilog/float_adder.sv
verilog/neuron_node.sv
verilog/weight_regs.sv
verilog/nn_layer.sv
tests/nn_layer_props.sv
tests/nn_layer_tb.sv

// File: tests/nn_layer_props.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_settings.svh"

module nn_layer_props import nn_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input logic done,
	input layer_out_t result
);

	logic started; // first start seen since reset.

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			started <= 1'b0;
		else if (start)
			started <= 1'b1;
	end

	a_reset_done: assert property (@(posedge clk) !rst_n |=> !done)
		else $error("done high during or just after reset");

	a_idle_done: assert property (@(posedge clk) disable iff (!rst_n) !started |-> !done)
		else $error("done pulsed before any start");

	a_start_done: assert property (@(posedge clk) disable iff (!rst_n) start |-> ##2 done)
		else $error("done missing two edges after start");

	a_done_start: assert property (@(posedge clk) disable iff (!rst_n) done |-> $past(start, 2))
		else $error("done without a start two edges before");

	// the ReLU never lets a negative word out.
	genvar n;
	generate
		for (n = 0; n < `NN_NODES; n = n + 1)
		begin : g_relu
			a_relu: assert property (@(posedge clk) disable iff (!rst_n) done |-> !result[n][31])
				else $error("negative result word on node %0d", n);
		end
	endgenerate

endmodule

`default_nettype wire

// File: tests/nn_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_settings.svh"

module nn_layer_tb import fp_pkg::*, nn_pkg::*; ();

	logic clk;
	logic rst_n;
	logic start;
	act_vec_t act_in;
	logic wt_we;
	weight_wr_t wt_wr;
	logic done;
	layer_out_t result;

	real act_m [`NN_INPUTS];
	real wt_m [`NN_NODES][`NN_INPUTS]; // mirrors the weight block.
	layer_out_t exp_q [$];
	string name_q [$];
	int issued;
	int checked;

	nn_layer DUT (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.act_in(act_in),
		.wt_we(wt_we),
		.wt_wr(wt_wr),
		.done(done),
		.result(result));

	bind nn_layer nn_layer_props u_props (
		.clk(clk),
		.rst_n(rst_n),
		.start(start),
		.done(done),
		.result(result));

	initial
	begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic report_error(input string msg);
		$display("%s", msg);
		$display("test failed");
		$fatal(1, "stopped at first error");
	endtask

	// exact values only, so the double's top mantissa bits are the whole story.
	function automatic fp32_t to_fp32(input real r);
		logic [63:0] d;
		d = $realtobits(r);
		if (d[62:0] == '0)
			return '0;
		return {d[63], 8'(d[62:52] - 11'd896), d[51:29]};
	endfunction

	function automatic real rand_half();
		int h;
		h = int'($urandom_range(16, 0)) - 8;
		return h / 2.0; // -4.0 to 4.0 in halves.
	endfunction

	function automatic layer_out_t model_layer();
		layer_out_t res;
		real p [`NN_INPUTS];
		real s [`NN_INPUTS/2];
		real total;
		for (int n = 0; n < `NN_NODES; n++)
		begin
			for (int i = 0; i < `NN_INPUTS; i++)
				p[i] = act_m[i] * wt_m[n][i];
			for (int j = 0; j < `NN_INPUTS/2; j++)
				s[j] = p[2*j] + p[2*j+1];
			total = ((s[0] + s[1]) + (s[2] + s[3])) + s[4];
			res[n] = (total > 0.0) ? to_fp32(total) : '0;
		end
		return res;
	endfunction

	task automatic write_weight(input int node, input int idx, input real value);
		@(posedge clk);
		wt_we <= 1'b1;
		wt_wr <= {node_idx_t'(node), in_idx_t'(idx), to_fp32(value)};
		if (idx < `NN_INPUTS)
			wt_m[node][idx] = value;
		@(posedge clk);
		wt_we <= 1'b0;
	endtask

	task automatic random_weights();
		for (int n = 0; n < `NN_NODES; n++)
			for (int i = 0; i < `NN_INPUTS; i++)
				write_weight(n, i, rand_half());
	endtask

	task automatic send_vector(input string name);
		act_vec_t bits;
		for (int i = 0; i < `NN_INPUTS; i++)
			bits[i] = to_fp32(act_m[i]);
		@(posedge clk);
		start <= 1'b1;
		act_in <= bits;
		exp_q.push_back(model_layer());
		name_q.push_back(name);
		issued++;
	endtask

	task automatic wait_drain(input string name);
		int cycles;
		@(posedge clk);
		start <= 1'b0;
		cycles = 0;
		while (exp_q.size() != 0 && cycles < 20)
		begin
			@(posedge clk);
			cycles++;
		end
		if (exp_q.size() != 0)
			report_error($sformatf("done never arrived in test %s", name));
	endtask

	task automatic check_result(input layer_out_t expected, input string name);
		for (int n = 0; n < `NN_NODES; n++)
			assert (result[n] == expected[n])
			else report_error($sformatf("[ERROR] %s: node %0d expected %h actual %h",
				name, n, expected[n], result[n]));
		checked++;
	endtask

	always @(posedge clk)
	begin
		if (rst_n && done)
		begin
			if (exp_q.size() == 0)
				report_error("done pulsed with no vector outstanding");
			else
				check_result(exp_q.pop_front(), name_q.pop_front());
		end
	end

	initial
	begin
		int sel;
		void'($urandom(63));
		rst_n = 1'b0;
		start = 1'b0;
		act_in = '0;
		wt_we = 1'b0;
		wt_wr = '0;
		issued = 0;
		checked = 0;
		foreach (wt_m[n, i])
			wt_m[n][i] = 0.0;
		repeat (16) @(posedge clk);
		rst_n <= 1'b1;

		foreach (act_m[i])
			act_m[i] = rand_half();
		send_vector("reset_zero");
		wait_drain("reset_zero");

		for (int k = 0; k < `NN_NODES; k++)
		begin
			sel = $urandom_range(`NN_INPUTS - 1, 0);
			write_weight(k, sel, 1.0);
			foreach (act_m[i])
				act_m[i] = rand_half();
			act_m[sel] = 2.5; // positive, so the ReLU lets it through.
			send_vector("pass_through");
			wait_drain("pass_through");
			write_weight(k, sel, 0.0);
		end

		repeat (12)
		begin
			random_weights();
			foreach (act_m[i])
				act_m[i] = rand_half();
			send_vector("random_exact");
			wait_drain("random_exact");
		end

		// node 0 negative, node 1 positive, node 2 slightly negative, node 3 cancels.
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			act_m[i] = 1.5;
			write_weight(0, i, -1.0);
			write_weight(1, i, 1.0);
			write_weight(2, i, (i == 9) ? 4.0 : -0.5);
			write_weight(3, i, (i < 5) ? 1.0 : -1.0);
		end
		send_vector("relu");
		wait_drain("relu");

		random_weights();
		repeat (8)
		begin
			foreach (act_m[i])
				act_m[i] = rand_half();
			send_vector("back_to_back");
		end
		wait_drain("back_to_back");

		for (int idx = `NN_INPUTS; idx < 16; idx++)
			write_weight($urandom_range(`NN_NODES - 1, 0), idx, 3.0);
		send_vector("bad_index");
		wait_drain("bad_index");
		write_weight(2, 4, 3.75);
		foreach (act_m[i])
			act_m[i] = 0.0;
		act_m[4] = 2.0; // node 2 now gives 7.5, which no half-step weight can produce.
		send_vector("rewrite");
		wait_drain("rewrite");

		repeat (4) @(posedge clk);
		if (issued == checked && exp_q.size() == 0)
		begin
			$display("test passed");
			$finish;
		end
		else
			report_error($sformatf("%0d vectors sent but %0d results checked", issued, checked));
	end

endmodule

`default_nettype wire

// File: verilog/float_adder.sv
`timescale 1ns/1ps
`default_nettype none

module float_adder import fp_pkg::*; (
	input fp32_t a,
	input fp32_t b,
	output fp32_t sum
);

	fp_fields_t fa;
	fp_fields_t fb;
	fp_fields_t op_hi;
	fp_fields_t op_lo;
	fp_fields_t fs;
	logic [23:0] sig_hi;
	logic [23:0] sig_lo;
	fp_exp_t diff;
	logic [49:0] lo_wide;
	logic [26:0] lo_al;
	logic [27:0] raw;
	logic [4:0] lz;
	logic [26:0] norm;
	logic signed [9:0] exp_norm;
	logic [24:0] sig_rnd;
	logic signed [9:0] exp_fin;

	assign fa = a;
	assign fb = b;

	// the operand with the larger magnitude sets sign and exponent.
	always_comb
	begin
		if ({fa.exp, fa.man} >= {fb.exp, fb.man})
		begin
			op_hi = fa;
			op_lo = fb;
		end
		else
		begin
			op_hi = fb;
			op_lo = fa;
		end
	end

	assign sig_hi = (op_hi.exp == '0) ? 24'd0 : {1'b1, op_hi.man}; // subnormals read as zero.
	assign sig_lo = (op_lo.exp == '0) ? 24'd0 : {1'b1, op_lo.man};
	assign diff = op_hi.exp - op_lo.exp;
	assign lo_wide = {sig_lo, 26'd0} >> diff;

	// frame is 24 significand bits, then guard, round and sticky.
	assign lo_al = (diff >= 8'd26) ? {26'd0, |sig_lo}
		: {lo_wide[49:24], |lo_wide[23:0]};

	// op_hi is never smaller, so the difference cannot go negative.
	assign raw = (op_hi.sign ^ op_lo.sign) ? {1'b0, sig_hi, 3'd0} - {1'b0, lo_al}
		: {1'b0, sig_hi, 3'd0} + {1'b0, lo_al};

	always_comb
	begin
		lz = 5'd0;
		for (int i = 0; i < 27; i++)
			if (raw[i])
				lz = 5'(26 - i); // the highest set bit wins.
	end

	always_comb
	begin
		if (raw[27])
		begin
			norm = {raw[27:2], raw[1] | raw[0]}; // carry out, shift right once.
			exp_norm = $signed({2'b00, op_hi.exp}) + 10'sd1;
		end
		else
		begin
			norm = raw[26:0] << lz;
			exp_norm = $signed({2'b00, op_hi.exp}) - $signed({5'd0, lz});
		end
	end

	assign sig_rnd = {1'b0, norm[26:3]} + {24'd0, norm[2] & (norm[1] | norm[0] | norm[3])};
	assign exp_fin = exp_norm + $signed({9'd0, sig_rnd[24]});

	always_comb
	begin
		fs.sign = op_hi.sign;
		fs.exp = exp_fin[7:0];
		fs.man = sig_rnd[22:0];
		if (raw == '0 || exp_fin <= 10'sd0)
			fs = '0; // exact cancellation and underflow both give +0.
		else if (exp_fin >= 10'sd255)
		begin
			fs.exp = '1;
			fs.man = '0;
		end
	end

	assign sum = fs;

endmodule

`default_nettype wire

// File: verilog/float_mult.sv
`timescale 1ns/1ps
`default_nettype none

module float_mult import fp_pkg::*; (
	input fp32_t x,
	input fp32_t y,
	output fp32_t z
);

	fp_fields_t fx;
	fp_fields_t fy;
	fp_fields_t fz;
	logic [47:0] prod;
	logic [23:0] sig;
	logic guard;
	logic sticky;
	logic [24:0] sig_rnd;
	logic signed [9:0] exp_sum;
	logic signed [9:0] exp_fin;

	assign fx = x;
	assign fy = y;

	assign prod = {1'b1, fx.man} * {1'b1, fy.man}; // product lies in [1,4).
	assign exp_sum = $signed({2'b00, fx.exp}) + $signed({2'b00, fy.exp}) - 10'sd127;

	always_comb
	begin
		if (prod[47])
		begin
			sig = prod[47:24];
			guard = prod[23];
			sticky = |prod[22:0];
		end
		else
		begin
			sig = prod[46:23];
			guard = prod[22];
			sticky = |prod[21:0];
		end
	end

	// ties go to the even significand.
	assign sig_rnd = {1'b0, sig} + {24'd0, guard & (sticky | sig[0])};

	// both the normalization shift and a rounding carry bump the exponent.
	assign exp_fin = exp_sum + $signed({9'd0, prod[47]}) + $signed({9'd0, sig_rnd[24]});

	always_comb
	begin
		fz.sign = fx.sign ^ fy.sign;
		fz.exp = exp_fin[7:0];
		fz.man = sig_rnd[22:0]; // all zero after a rounding carry.
		if (fx.exp == '0 || fy.exp == '0 || exp_fin <= 10'sd0)
			fz = '0;
		else if (exp_fin >= 10'sd255)
		begin
			fz.exp = '1; // infinity keeps the product sign.
			fz.man = '0;
		end
	end

	assign z = fz;

endmodule

`default_nettype wire

// File: verilog/fp_pkg.sv
`default_nettype none

package fp_pkg;

	// raw single-precision word as it moves through the datapath.
	typedef logic [31:0] fp32_t;

	typedef logic [7:0] fp_exp_t;  // biased by 127.
	typedef logic [22:0] fp_man_t; // hidden one not stored.

	// the same 32 bits with the fields named, msb first.
	typedef struct packed {
		logic sign;
		fp_exp_t exp;
		fp_man_t man;
	} fp_fields_t;

endpackage

`default_nettype wire

// File: verilog/neuron_node.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_settings.svh"

module neuron_node import fp_pkg::*, nn_pkg::*; (
	input act_vec_t act,
	input act_vec_t weights,
	output fp32_t y
);

	fp32_t [`NN_INPUTS-1:0] prod;
	fp32_t [`NN_INPUTS/2-1:0] pair_sum;
	fp32_t quad_lo;
	fp32_t quad_hi;
	fp32_t oct_sum;
	fp_fields_t total;

	genvar i;
	generate
		for (i = 0; i < `NN_INPUTS; i = i + 1)
		begin : g_mult
			float_mult u_mult (
				.x(act[i]),
				.y(weights[i]),
				.z(prod[i]));
		end

		// first level adds neighbouring products (0,1) through (8,9).
		for (i = 0; i < `NN_INPUTS/2; i = i + 1)
		begin : g_pair
			float_adder u_add (
				.a(prod[2*i]),
				.b(prod[2*i+1]),
				.sum(pair_sum[i]));
		end
	endgenerate

	float_adder u_add_quad_lo (
		.a(pair_sum[0]),
		.b(pair_sum[1]),
		.sum(quad_lo));

	float_adder u_add_quad_hi (
		.a(pair_sum[2]),
		.b(pair_sum[3]),
		.sum(quad_hi));

	float_adder u_add_oct (
		.a(quad_lo),
		.b(quad_hi),
		.sum(oct_sum));

	// the last pair joins at the end, so rounding matches the software model.
	float_adder u_add_final (
		.a(oct_sum),
		.b(pair_sum[4]),
		.sum(total));

	assign y = total.sign ? '0 : fp32_t'(total); // ReLU.

endmodule

`default_nettype wire

// File: verilog/nn_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_settings.svh"

module nn_layer import nn_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic start,
	input act_vec_t act_in,
	input logic wt_we,
	input weight_wr_t wt_wr,
	output logic done,
	output layer_out_t result
);

	act_vec_t act_q;
	logic act_vld;
	act_vec_t [`NN_NODES-1:0] node_weights;
	layer_out_t node_y;

	weight_regs u_weight_regs (
		.clk(clk),
		.rst_n(rst_n),
		.wt_we(wt_we),
		.wt_wr(wt_wr),
		.node_weights(node_weights));

	// every node reads the same registered vector in the compute cycle.
	genvar n;
	generate
		for (n = 0; n < `NN_NODES; n = n + 1)
		begin : g_node
			neuron_node u_node (
				.act(act_q),
				.weights(node_weights[n]),
				.y(node_y[n]));
		end
	endgenerate

	always_ff @(posedge clk)
	begin
		if (start)
			act_q <= act_in;
	end

	always_ff @(posedge clk)
	begin
		if (!rst_n)
		begin
			act_vld <= 1'b0;
			done <= 1'b0;
			result <= '0;
		end
		else
		begin
			act_vld <= start;
			done <= act_vld; // second edge after start.
			if (act_vld)
				result <= node_y;
		end
	end

endmodule

`default_nettype wire

// File: verilog/nn_pkg.sv
`default_nettype none

`include "nn_settings.svh"

package nn_pkg;
	import fp_pkg::*;

	typedef logic [$clog2(`NN_INPUTS)-1:0] in_idx_t; // input slot within a node.
	typedef logic [$clog2(`NN_NODES)-1:0] node_idx_t;

	// element i is activation (or weight) i of a node.
	typedef fp32_t [`NN_INPUTS-1:0] act_vec_t;

	// element n is the ReLU output of node n.
	typedef fp32_t [`NN_NODES-1:0] layer_out_t;

	// a single weight update, applied on the strobe edge.
	typedef struct packed {
		node_idx_t node;
		in_idx_t idx;
		fp32_t data;
	} weight_wr_t;

endpackage

`default_nettype wire

// File: verilog/nn_settings.svh
`ifndef NN_SETTINGS_SVH
`define NN_SETTINGS_SVH

// one node sees this many activations, each with its own weight.
// the adder tree in neuron_node is laid out for exactly ten.
`define NN_INPUTS 10

// nodes in one layer. All of them share the same input vector.
`define NN_NODES 4

`endif

// File: verilog/weight_regs.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_settings.svh"

module weight_regs import nn_pkg::*; (
	input logic clk,
	input logic rst_n,
	input logic wt_we,
	input weight_wr_t wt_wr,
	output act_vec_t [`NN_NODES-1:0] node_weights
);

	logic wr_ok;

	// slots 10 to 15 of the index do not exist and are dropped.
	assign wr_ok = wt_we && (wt_wr.idx < `NN_INPUTS);

	always_ff @(posedge clk)
	begin
		if (!rst_n)
			node_weights <= '0; // an unloaded layer outputs zeros.
		else if (wr_ok)
			node_weights[wt_wr.node][wt_wr.idx] <= wt_wr.data;
	end

endmodule

`default_nettype wire
